// File: Makefile
# Verilator build and run of the power-gated queue testbench

VERILATOR ?= verilator
TOP       ?= tb_rf_queue
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
source/rf_pkg.sv
source/rf_pg_4x139.sv
source/pg_ctrl.sv
source/queue_wr_stage.sv
source/queue_rd_stage.sv
source/rf_queue_top.sv
verification/rf_queue_checker.sv
verification/tb_rf_queue.sv

// File: source/pg_ctrl.sv
// Power-gate sequencer of the register file, gates intake and orders isolation around power removal
`timescale 1ns/1ps

module pg_ctrl (
     input  logic  clk
    ,input  logic  rst_n

    ,input  logic  sleep_req
    ,input  logic  queue_idle

    // Power chain of the storage
    ,input  logic  pwr_enable_b_out
    ,output logic  pgcb_isol_en
    ,output logic  pwr_enable_b_in

    ,output logic  accept_en
);

    import rf_pkg::*;

    pg_state_t state_q;
    pg_state_t state_nxt;

    // Intake enable, registered so it is low through reset
    logic      accept_q;
    logic      go_sleep;

    // Sleep is only allowed with nothing stored and nothing in flight
    assign go_sleep = sleep_req && queue_idle;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    always_comb begin
        state_nxt = state_q;
        unique case (state_q)
            // Intake closes one cycle ahead, so no push can race the decision
            PG_AWAKE: begin
                if (go_sleep && !accept_q) begin
                    state_nxt = PG_ISOLATING;
                end
            end
            PG_ISOLATING: begin
                state_nxt = PG_ASLEEP;
            end
            PG_ASLEEP: begin
                if (!sleep_req) begin
                    state_nxt = PG_POWER_UP;
                end
            end
            // Wait for the end of the chain to report power again
            PG_POWER_UP: begin
                if (!pwr_enable_b_out) begin
                    state_nxt = PG_DEISOLATING;
                end
            end
            PG_DEISOLATING: begin
                state_nxt = PG_AWAKE;
            end
            default: begin
                state_nxt = PG_AWAKE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= PG_AWAKE;
            accept_q <= 1'b0;
        end else begin
            state_q  <= state_nxt;
            // A pending sleep with an idle queue closes intake first
            accept_q <= (state_nxt == PG_AWAKE) && !go_sleep;
        end
    end

    // Isolation is held from before power removal until power is back
    assign pgcb_isol_en    = (state_q == PG_ISOLATING) || (state_q == PG_ASLEEP) ||
                             (state_q == PG_POWER_UP);
    assign pwr_enable_b_in = (state_q == PG_ASLEEP);
    assign accept_en       = accept_q;

    // The storage never reports lost power without isolation in place
    a_isol_covers_power : assert property (
        @(posedge clk) disable iff (!rst_n) !pgcb_isol_en |-> !pwr_enable_b_out
    ) else $error("power disabled while isolation is low");

endmodule

// File: source/queue_rd_stage.sv
// Read stage of the queue, fetches register file entries into a two-entry output skid
`timescale 1ns/1ps

module queue_rd_stage (
     input  logic                clk
    ,input  logic                rst_n

    ,input  rf_pkg::rf_ptr_t     wr_ptr
    ,output rf_pkg::rf_ptr_t     rd_ptr

    // Register file read port, data returns one cycle after the request
    ,output rf_pkg::rf_rd_req_t  rd_req
    ,input  rf_pkg::rf_data_t    rdata

    // Output stream
    ,output logic                out_valid
    ,output rf_pkg::rf_data_t    out_data
    ,input  logic                out_ready

    ,output logic                queue_idle
);

    import rf_pkg::*;

    rf_ptr_t    rd_ptr_q;
    logic       rd_pending_q;

    // Skid storage has no reset, only its indices and count do
    rf_data_t   skid_q [SKID_DEPTH];
    logic       skid_wr_idx_q;
    logic       skid_rd_idx_q;
    logic [1:0] skid_cnt_q;

    logic [1:0] inflight;
    logic       empty;
    logic       room;
    logic       rd_en;
    logic       pop;

    // ----------------------------------------
    // Read issue
    // ----------------------------------------

    assign empty = (wr_ptr == rd_ptr_q);
    assign pop   = out_valid && out_ready;

    // Words held in the skid plus the one still coming from the array
    assign inflight = skid_cnt_q + {1'b0, rd_pending_q};

    // A pop this cycle frees a slot in time for the next returning word
    assign room  = (inflight < 2'(SKID_DEPTH)) || pop;
    assign rd_en = !empty && room;

    assign rd_req = '{re: rd_en, addr: rd_ptr_q[RF_ADDR_W-1:0]};
    assign rd_ptr = rd_ptr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q      <= '0;
            rd_pending_q  <= 1'b0;
            skid_wr_idx_q <= 1'b0;
            skid_rd_idx_q <= 1'b0;
            skid_cnt_q    <= '0;
        end else begin
            rd_pending_q <= rd_en;
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + rf_ptr_t'(1);
            end
            if (rd_pending_q) begin
                skid_wr_idx_q <= !skid_wr_idx_q;
            end
            if (pop) begin
                skid_rd_idx_q <= !skid_rd_idx_q;
            end
            // Count moves only when a landing and a pop do not cancel out
            if (rd_pending_q && !pop) begin
                skid_cnt_q <= skid_cnt_q + 2'd1;
            end else if (!rd_pending_q && pop) begin
                skid_cnt_q <= skid_cnt_q - 2'd1;
            end
        end
    end

    // ----------------------------------------
    // Output skid
    // ----------------------------------------

    // The returned word lands in the slot under the write index
    always_ff @(posedge clk) begin
        if (rd_pending_q) begin
            skid_q[skid_wr_idx_q] <= rdata;
        end
    end

    assign out_valid = (skid_cnt_q != '0);
    assign out_data  = skid_q[skid_rd_idx_q];

    // Idle also needs the array read in flight to have landed
    assign queue_idle = empty && !rd_pending_q && (skid_cnt_q == '0);

    // A word returning from the array always finds a free skid slot
    a_skid_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_pending_q |-> (skid_cnt_q < 2'(SKID_DEPTH)) || pop
    ) else $error("output skid overflow");

    // A stalled output word holds until it is taken
    a_out_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("output word changed under back-pressure");

endmodule

// File: source/queue_wr_stage.sv
// Push stage of the queue, turns handshaked input words into register file write requests
`timescale 1ns/1ps

module queue_wr_stage (
     input  logic                clk
    ,input  logic                rst_n

    // Input stream
    ,input  logic                in_valid
    ,input  rf_pkg::rf_data_t    in_data
    ,output logic                in_ready

    ,input  logic                accept_en
    ,input  rf_pkg::rf_ptr_t     rd_ptr
    ,output rf_pkg::rf_ptr_t     wr_ptr

    ,output rf_pkg::rf_wr_req_t  wr_req
);

    import rf_pkg::*;

    rf_ptr_t wr_ptr_q;
    logic    full;
    logic    push;

    // Full when the addresses match but the wrap bits differ
    assign full = (wr_ptr_q[RF_ADDR_W] != rd_ptr[RF_ADDR_W]) &&
                  (wr_ptr_q[RF_ADDR_W-1:0] == rd_ptr[RF_ADDR_W-1:0]);

    // Intake also closes while the power controller prepares for sleep
    assign in_ready = accept_en && !full;
    assign push     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (push) begin
            wr_ptr_q <= wr_ptr_q + rf_ptr_t'(1);
        end
    end

    assign wr_ptr = wr_ptr_q;

    // The word goes straight into the entry under the write pointer
    assign wr_req = '{we: push, addr: wr_ptr_q[RF_ADDR_W-1:0], data: in_data};

    // Occupancy seen from both stages never exceeds the register file depth
    a_no_overfill : assert property (
        @(posedge clk) disable iff (!rst_n)
        rf_ptr_t'(wr_ptr_q - rd_ptr) <= rf_ptr_t'(RF_DEPTH)
    ) else $error("register file written while full");

endmodule

// File: source/rf_pg_4x139.sv
// Model of the power-gated 4x139 two-port register file macro, used as the storage of the queue
`timescale 1ns/1ps

module rf_pg_4x139 (
     input  logic                wclk
    ,input  logic                wclk_rst_n
    ,input  rf_pkg::rf_wr_req_t  wr_req

    ,input  logic                rclk
    ,input  logic                rclk_rst_n
    ,input  rf_pkg::rf_rd_req_t  rd_req

    ,output rf_pkg::rf_data_t    rdata

    // Power management of the macro
    ,input  logic                pgcb_isol_en
    ,input  logic                pwr_enable_b_in
    ,output logic                pwr_enable_b_out

    ,input  logic                ip_reset_b

    ,input  logic                fscan_byprst_b
    ,input  logic                fscan_rstbypen
);

    import rf_pkg::*;

    // Array and registered read data, both include the spare bit
    rf_store_t  mem_q [RF_DEPTH];
    rf_store_t  rdata_q;

    // Macro reset after the two-flop synchronizer and the scan mux
    logic [1:0] rst_sync_q;
    logic       ip_reset_b_sync;

    // Last stage of the power-enable daisy chain
    logic       pwr_chain_q;
    logic       pwr_off;

    // ----------------------------------------
    // Macro reset synchronizer
    // ----------------------------------------

    // Asserts asynchronously and releases two read clocks later
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rst_sync_q <= '0;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    // In scan mode the reset comes straight from the scan pin
    assign ip_reset_b_sync = fscan_rstbypen ? fscan_byprst_b : rst_sync_q[1];

    // ----------------------------------------
    // Power-enable chain
    // ----------------------------------------

    // The chain output follows its input one cycle later, starting powered
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            pwr_chain_q <= 1'b0;
        end else begin
            pwr_chain_q <= pwr_enable_b_in;
        end
    end

    assign pwr_enable_b_out = pwr_chain_q;

    // The array counts as unpowered until both ends of the chain report power
    assign pwr_off = pwr_enable_b_in | pwr_chain_q;

    // ----------------------------------------
    // Array access
    // ----------------------------------------

    // Spare bit is written as zero, writes are dropped when isolated or unpowered
    always_ff @(posedge wclk) begin
        if (wclk_rst_n && wr_req.we && !pgcb_isol_en && !pwr_off) begin
            mem_q[wr_req.addr] <= {1'b0, wr_req.data};
        end
    end

    // Read data register, cleared by the synchronized macro reset
    always_ff @(posedge rclk or negedge ip_reset_b_sync) begin
        if (!ip_reset_b_sync) begin
            rdata_q <= '0;
        end else if (rclk_rst_n && rd_req.re && !pwr_off) begin
            rdata_q <= mem_q[rd_req.addr];
        end
    end

    // Isolation clamps the output to zero and the spare bit is dropped here
    assign rdata = (pgcb_isol_en || pwr_off) ? '0 : rdata_q[RF_WIDTH-1:0];

    // The power controller only sleeps an empty queue, so no access may meet a power-down
    a_no_write_unpowered : assert property (
        @(posedge wclk) disable iff (!wclk_rst_n) wr_req.we |-> !pwr_off
    ) else $error("register file written while power is disabled");

    a_no_read_unpowered : assert property (
        @(posedge rclk) disable iff (!rclk_rst_n) rd_req.re |-> !pwr_off
    ) else $error("register file read while power is disabled");

endmodule

// File: source/rf_pkg.sv
// Shared sizes, vector types, request structs and power states of the queue, imported in each module body
package rf_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Number of entries in the register file macro
    localparam int RF_DEPTH = 4;

    // User data width of one queue word
    localparam int RF_WIDTH = 139;

    // Entry address width, log2 of the depth
    localparam int RF_ADDR_W = 2;

    // Queue pointers carry one extra wrap bit above the address
    localparam int RF_PTR_W = RF_ADDR_W + 1;

    // The macro stores one spare bit above the user data
    localparam int RF_STORE_W = RF_WIDTH + 1;

    // Entries in the output skid behind the register file
    localparam int SKID_DEPTH = 2;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    typedef logic [RF_ADDR_W-1:0]  rf_addr_t;
    typedef logic [RF_PTR_W-1:0]   rf_ptr_t;
    typedef logic [RF_WIDTH-1:0]   rf_data_t;
    typedef logic [RF_STORE_W-1:0] rf_store_t;

    // Write port request of the register file, sampled on the write clock
    typedef struct packed {
        logic     we;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    // Read port request, data returns in the following cycle
    typedef struct packed {
        logic     re;
        rf_addr_t addr;
    } rf_rd_req_t;

    // Power-gate sequence, isolation always wraps the time without power
    typedef enum logic [2:0] {
        PG_AWAKE,
        PG_ISOLATING,
        PG_ASLEEP,
        PG_POWER_UP,
        PG_DEISOLATING
    } pg_state_t;

endpackage

// File: source/rf_queue_top.sv
// Top level of the power-gated register file queue, wires the stages, the storage and the power controller
`timescale 1ns/1ps

module rf_queue_top (
     input  logic              clk
    ,input  logic              rst_n

    // Input stream
    ,input  logic              in_valid
    ,input  rf_pkg::rf_data_t  in_data
    ,output logic              in_ready

    // Output stream
    ,output logic              out_valid
    ,output rf_pkg::rf_data_t  out_data
    ,input  logic              out_ready

    ,input  logic              sleep_req

    // Scan reset bypass of the macro
    ,input  logic              fscan_byprst_b
    ,input  logic              fscan_rstbypen
);

    import rf_pkg::*;

    // Pointer exchange, each stage owns one pointer
    rf_ptr_t    wr_ptr;
    rf_ptr_t    rd_ptr;

    // Register file ports
    rf_wr_req_t wr_req;
    rf_rd_req_t rd_req;
    rf_data_t   rdata;

    // Power management
    logic       accept_en;
    logic       queue_idle;
    logic       pgcb_isol_en;
    logic       pwr_enable_b_in;
    logic       pwr_enable_b_out;

    queue_wr_stage i_wr_stage (
         .clk                (clk)
        ,.rst_n              (rst_n)
        ,.in_valid           (in_valid)
        ,.in_data            (in_data)
        ,.in_ready           (in_ready)
        ,.accept_en          (accept_en)
        ,.rd_ptr             (rd_ptr)
        ,.wr_ptr             (wr_ptr)
        ,.wr_req             (wr_req)
    );

    // Both clock domains of the macro run from the single queue clock
    rf_pg_4x139 i_rf (
         .wclk               (clk)
        ,.wclk_rst_n         (rst_n)
        ,.wr_req             (wr_req)
        ,.rclk               (clk)
        ,.rclk_rst_n         (rst_n)
        ,.rd_req             (rd_req)
        ,.rdata              (rdata)
        ,.pgcb_isol_en       (pgcb_isol_en)
        ,.pwr_enable_b_in    (pwr_enable_b_in)
        ,.pwr_enable_b_out   (pwr_enable_b_out)
        ,.ip_reset_b         (rst_n)
        ,.fscan_byprst_b     (fscan_byprst_b)
        ,.fscan_rstbypen     (fscan_rstbypen)
    );

    queue_rd_stage i_rd_stage (
         .clk                (clk)
        ,.rst_n              (rst_n)
        ,.wr_ptr             (wr_ptr)
        ,.rd_ptr             (rd_ptr)
        ,.rd_req             (rd_req)
        ,.rdata              (rdata)
        ,.out_valid          (out_valid)
        ,.out_data           (out_data)
        ,.out_ready          (out_ready)
        ,.queue_idle         (queue_idle)
    );

    pg_ctrl i_pg_ctrl (
         .clk                (clk)
        ,.rst_n              (rst_n)
        ,.sleep_req          (sleep_req)
        ,.queue_idle         (queue_idle)
        ,.pwr_enable_b_out   (pwr_enable_b_out)
        ,.pgcb_isol_en       (pgcb_isol_en)
        ,.pwr_enable_b_in    (pwr_enable_b_in)
        ,.accept_en          (accept_en)
    );

endmodule

// File: verification/rf_queue_checker.sv
// Scoreboard of the queue testbench, mirrors every accepted word and checks each output transfer
`timescale 1ns/1ps

module rf_queue_checker (
     input  logic              clk
    ,input  logic              rst_n

    // DUT ports under observation
    ,input  logic              in_valid
    ,input  rf_pkg::rf_data_t  in_data
    ,input  logic              in_ready
    ,input  logic              out_valid
    ,input  rf_pkg::rf_data_t  out_data
    ,input  logic              out_ready
    ,input  logic              sleep_req

    // Test markers and level checks requested by the replay
    ,input  int                test_id
    ,input  logic              check_req
    ,input  logic [7:0]        check_kind
    ,input  int                check_arg
    ,input  logic              end_req

    ,output int                pending
    ,output int                errors
    ,output logic              report_done
);

    import rf_pkg::*;

    // Reference queue, in push order
    rf_data_t ref_q [$];
    rf_data_t expected;

    int   cur_test      = 0;
    int   test_errs     = 0;
    int   test_in       = 0;
    int   test_out      = 0;
    int   tests_run     = 0;
    int   tests_failed  = 0;
    int   words_checked = 0;
    int   err_total     = 0;
    int   queued        = 0;
    logic in_ready_d    = 1'b0;
    logic done_q        = 1'b0;

    assign pending     = queued;
    assign errors      = err_total;
    assign report_done = done_q;

    task automatic note_error();
        test_errs++;
        err_total++;
    endtask

    task automatic compare_value(input string what, input int exp_val, input int seen);
        if (exp_val != seen) begin
            $display("[FAIL] %0d ns: test %0d, %s expected %0d, saw %0d",
                     $time, cur_test, what, exp_val, seen);
            note_error();
        end
    endtask

    // One line per finished test
    task automatic report_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d words in, %0d words out, %0d errors",
                 cur_test, (test_errs == 0) ? "passed" : "failed", test_in, test_out, test_errs);
    endtask

    // ----------------------------------------
    // Sampling at the rising edge
    // ----------------------------------------

    always @(posedge clk) begin
        if (rst_n && !done_q) begin
            // A new marker closes the previous test
            if (test_id != cur_test) begin
                if (cur_test != 0) begin
                    report_test();
                end
                cur_test  = test_id;
                test_errs = 0;
                test_in   = 0;
                test_out  = 0;
            end
            if (in_valid && in_ready) begin
                ref_q.push_back(in_data);
                test_in++;
            end
            if (out_valid && out_ready) begin
                test_out++;
                if (ref_q.size() == 0) begin
                    $display("Output transfer at %0d ns in test %0d with no word queued",
                             $time, cur_test);
                    note_error();
                end else begin
                    expected = ref_q.pop_front();
                    words_checked++;
                    if (out_data !== expected) begin
                        $display("[FAIL] %0d ns: test %0d, output word %0d expected %h, saw %h",
                                 $time, cur_test, test_out, expected, out_data);
                        note_error();
                    end
                end
            end
            // Intake may only close for sleep once every queued word has left
            if (sleep_req && in_ready_d && !in_ready && ref_q.size() != 0) begin
                $display("Intake closed for sleep at %0d ns while %0d words were still queued",
                         $time, ref_q.size());
                note_error();
            end
            in_ready_d = in_ready;
            if (check_req) begin
                case (check_kind)
                    "I": compare_value("in_ready", check_arg, 32'(in_ready));
                    "O": compare_value("out_valid", check_arg, 32'(out_valid));
                    "A": compare_value("accepted words", check_arg, test_in);
                    "Q": compare_value("queued words", check_arg, ref_q.size());
                    default: begin
                        $display("Unknown check '%c' requested at %0d ns", check_kind, $time);
                        note_error();
                    end
                endcase
            end
            queued = ref_q.size();
            if (end_req) begin
                if (ref_q.size() != 0) begin
                    $display("%0d words were accepted but never delivered", ref_q.size());
                    note_error();
                end
                report_test();
                $display("Summary: %0d tests, %0d passed, %0d failed, %0d words compared, %0d errors",
                         tests_run, tests_run - tests_failed, tests_failed, words_checked,
                         err_total);
                done_q = 1'b1;
            end
        end
    end

endmodule

// File: verification/rf_queue_stim.txt
# Columns: command letter, then decimal arguments; W takes one 139-bit word in hex
# T test, R out_ready (0 low 1 high 2 random), S sleep level, H hold cycles, P count valid_mode,
# V offer cycles, Z drain, checks I in_ready, O out_valid, A accepted count, Q queued count
T 1
O 0
I 1
Q 0
T 2
R 1
W 7ffffffffffffffffffffffffffffffffff
W 40000000000000000000000000000000001
W 5aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
P 32 0
Z
Q 0
A 35
T 3
R 0
V 16
A 6
I 0
O 1
R 1
Z
Q 0
T 4
S 1
H 6
I 0
V 8
A 0
S 0
H 10
I 1
P 12 0
Z
A 12
T 5
R 0
P 3 0
S 1
H 6
I 1
Q 3
R 1
Z
H 6
I 0
S 0
H 10
I 1
T 6
R 2
P 200 1
R 1
Z
Q 0
A 200

// File: verification/tb_rf_queue.sv
// Testbench top of the power-gated queue, replays the stim file into the DUT and gives the verdict
`timescale 1ns/1ps

module tb_rf_queue;

    import rf_pkg::*;

    localparam string STIM_FILE     = "verification/rf_queue_stim.txt";
    localparam int    CLK_HALF      = 4;
    localparam int    RESET_CYCLES  = 4;
    localparam int    MARGIN_CYCLES = 500;

    // Longest a drain may take before the queue counts as stuck
    localparam int    DRAIN_CYCLES  = 64;

    // DUT ports
    logic     clk;
    logic     rst_n;
    logic     in_valid;
    rf_data_t in_data;
    logic     in_ready;
    logic     out_valid;
    rf_data_t out_data;
    logic     out_ready;
    logic     sleep_req;
    logic     fscan_byprst_b;
    logic     fscan_rstbypen;

    // Links to the checker
    int         test_id;
    logic       check_req;
    logic [7:0] check_kind;
    int         check_arg;
    logic       end_req;
    int         pending;
    int         err_count;
    logic       report_done;

    // Replay state, applied to the pins at the next falling edge
    int   seed = 9269;
    int   test_num;
    int   ready_mode;
    logic sleep_level;
    logic check_pending;
    byte  check_op;
    int   check_val;
    logic end_pending;
    int   stim_errors;
    int   budget_cycles;
    logic budget_ready;

    // Parsed commands of the stim file
    byte      op_q [$];
    int       arg_a_q [$];
    int       arg_b_q [$];
    rf_data_t word_q [$];

    rf_queue_top i_dut (
         .clk            (clk)
        ,.rst_n          (rst_n)
        ,.in_valid       (in_valid)
        ,.in_data        (in_data)
        ,.in_ready       (in_ready)
        ,.out_valid      (out_valid)
        ,.out_data       (out_data)
        ,.out_ready      (out_ready)
        ,.sleep_req      (sleep_req)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.fscan_rstbypen (fscan_rstbypen)
    );

    rf_queue_checker i_checker (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.in_valid    (in_valid)
        ,.in_data     (in_data)
        ,.in_ready    (in_ready)
        ,.out_valid   (out_valid)
        ,.out_data    (out_data)
        ,.out_ready   (out_ready)
        ,.sleep_req   (sleep_req)
        ,.test_id     (test_id)
        ,.check_req   (check_req)
        ,.check_kind  (check_kind)
        ,.check_arg   (check_arg)
        ,.end_req     (end_req)
        ,.pending     (pending)
        ,.errors      (err_count)
        ,.report_done (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Rough cycle cost of one command, random handshakes get a generous share
    function automatic int cycle_cost(input byte op, input int a, input int b);
        case (op)
            "H", "V": return a;
            "P":      return (b == 0) ? a * 2 : a * 6;
            "W":      return 4;
            "Z":      return DRAIN_CYCLES + 1;
            default:  return 1;
        endcase
    endfunction

    task automatic next_word(output rf_data_t word);
        logic [159:0] raw;
        raw  = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        word = raw[RF_WIDTH-1:0];
    endtask

    // One clock of stimulus, taken tells whether the word transfers at the next rising edge
    task automatic drive_cycle(input logic valid, input rf_data_t word, output logic taken);
        int rnd;
        @(negedge clk);
        rnd        = $random(seed);
        in_valid   = valid;
        in_data    = word;
        sleep_req  = sleep_level;
        test_id    = test_num;
        check_req  = check_pending;
        check_kind = check_op;
        check_arg  = check_val;
        end_req    = end_pending;
        check_pending = 1'b0;
        case (ready_mode)
            0:       out_ready = 1'b0;
            1:       out_ready = 1'b1;
            default: out_ready = rnd[0];
        endcase
        // in_ready comes from registers only, so it is settled here
        taken = valid && in_ready;
    endtask

    task automatic hold_cycles(input int count);
        logic taken;
        repeat (count) drive_cycle(1'b0, '0, taken);
    endtask

    // Push a number of random words, valid stays high until each one is taken
    task automatic push_words(input int count, input int mode);
        int       sent;
        int       rnd;
        logic     offering;
        logic     taken;
        rf_data_t word;
        sent     = 0;
        offering = 1'b0;
        word     = '0;
        while (sent < count) begin
            rnd = $random(seed);
            if (!offering && (mode == 0 || rnd[0])) begin
                next_word(word);
                offering = 1'b1;
            end
            drive_cycle(offering, word, taken);
            if (taken) begin
                sent++;
                offering = 1'b0;
            end
        end
    endtask

    task automatic push_given(input rf_data_t word);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            drive_cycle(1'b1, word, taken);
        end
    endtask

    // Offer words for a fixed number of cycles, whether or not they are taken
    task automatic offer_words(input int count);
        logic     taken;
        rf_data_t word;
        next_word(word);
        repeat (count) begin
            drive_cycle(1'b1, word, taken);
            if (taken) begin
                next_word(word);
            end
        end
    endtask

    // Idle the input until every accepted word has left, or give up after a bounded wait
    task automatic drain_queue();
        logic taken;
        int   waited;
        waited = 0;
        drive_cycle(1'b0, '0, taken);
        while ((pending != 0 || out_valid) && waited < DRAIN_CYCLES) begin
            drive_cycle(1'b0, '0, taken);
            waited++;
        end
    endtask

    task automatic request_check(input byte op, input int value);
        logic taken;
        check_pending = 1'b1;
        check_op      = op;
        check_val     = value;
        drive_cycle(1'b0, '0, taken);
    endtask

    // ----------------------------------------
    // Stim file
    // ----------------------------------------

    task automatic load_stimulus();
        int       fd;
        int       n;
        int       a;
        int       b;
        byte      op;
        string    line;
        rf_data_t word;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
        end else begin
            budget_cycles = RESET_CYCLES + MARGIN_CYCLES;
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n == 0 || line.len() == 0) begin
                    continue;
                end
                op = line.getc(0);
                // Comment and blank lines carry no command
                if (op == "#" || op == " " || op == "\n" || op == "\r") begin
                    continue;
                end
                a    = 0;
                b    = 0;
                word = '0;
                if (op == "W") begin
                    n = $sscanf(line, "%c %h", op, word);
                end else begin
                    n = $sscanf(line, "%c %d %d", op, a, b);
                end
                op_q.push_back(op);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
                word_q.push_back(word);
                budget_cycles += cycle_cost(op, a, b);
            end
            $fclose(fd);
            budget_ready = 1'b1;
        end
    endtask

    task automatic run_stimulus();
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "T":                test_num = arg_a_q[i];
                "R":                ready_mode = arg_a_q[i];
                "S":                sleep_level = (arg_a_q[i] != 0);
                "H":                hold_cycles(arg_a_q[i]);
                "P":                push_words(arg_a_q[i], arg_b_q[i]);
                "W":                push_given(word_q[i]);
                "V":                offer_words(arg_a_q[i]);
                "Z":                drain_queue();
                "I", "O", "A", "Q": request_check(op_q[i], arg_a_q[i]);
                default: begin
                    $display("Unknown command '%c' in the stimulus file", op_q[i]);
                    stim_errors++;
                end
            endcase
        end
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin
        wait (budget_ready);
        repeat (budget_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", budget_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic taken;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        sleep_req      = 1'b0;
        fscan_byprst_b = 1'b1;
        fscan_rstbypen = 1'b0;
        test_id        = 0;
        check_req      = 1'b0;
        check_kind     = '0;
        check_arg      = 0;
        end_req        = 1'b0;
        test_num       = 0;
        ready_mode     = 1;
        sleep_level    = 1'b0;
        check_pending  = 1'b0;
        check_op       = 0;
        check_val      = 0;
        end_pending    = 1'b0;
        stim_errors    = 0;
        budget_cycles  = 0;
        budget_ready   = 1'b0;
        load_stimulus();
        if (!budget_ready) begin
            $display(">>> FAIL");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            run_stimulus();
            end_pending = 1'b1;
            drive_cycle(1'b0, '0, taken);
            wait (report_done);
            if (err_count == 0 && stim_errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
        end
        $finish;
    end

endmodule
